/* src/vlsu_pkg.sv */
//////////////////////////////////////////////////
// Vector load/store unit shared definitions
// Widths, bus types and encodings for all blocks
//////////////////////////////////////////////////

package vlsu_pkg;

    // Register and bus geometry
    localparam int VLEN         = 64;
    localparam int VLENB        = VLEN / 8;
    localparam int BUS_WIDTH    = 32;
    localparam int BUS_BYTES    = BUS_WIDTH / 8;

    // Cycles from address to read data, also the drain length
    localparam int READ_LATENCY = 2;

    typedef logic [VLEN-1:0]      vreg_t;
    typedef logic [31:0]          addr_t;
    typedef logic [BUS_WIDTH-1:0] bus_data_t;
    typedef logic [BUS_BYTES-1:0] byte_en_t;

    // Element slot within one register, up to 8 byte elements
    typedef logic [2:0]           elem_idx_t;
    typedef logic [VLENB-1:0]     elem_mask_t;

    // Encoded as log2 of the bytes per element
    typedef enum logic [1:0] {
        EW8  = 2'd0,
        EW16 = 2'd1,
        EW32 = 2'd2
    } elem_width_e;

    typedef enum logic [1:0] {
        LSU_IDLE   = 2'd0,
        LSU_ACCESS = 2'd1,
        LSU_DRAIN  = 2'd2
    } lsu_state_e;

endpackage

/* src/vlsu_fsm.sv */
//////////////////////////////////////////////////
// Load/store sequencer
// Steps through idle, access and drain phases
//////////////////////////////////////////////////

`timescale 1ns/1ps

module vlsu_fsm (
    input  logic                 clk,
    input  logic                 reset_n,
    input  logic                 start_i,
    input  logic                 is_store_i,
    input  logic                 last_elem_i,
    input  logic                 drain_done_i,
    output vlsu_pkg::lsu_state_e state_o,
    output logic                 count_clear_o
);
    import vlsu_pkg::*;

    lsu_state_e state_q;
    lsu_state_e state_d;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state_q <= LSU_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d = state_q;
        unique case (state_q)
            LSU_IDLE: begin
                if (start_i) begin
                    state_d = LSU_ACCESS;
                end
            end
            LSU_ACCESS: begin
                // Stores finish with the bus cycle, loads wait for data
                if (last_elem_i) begin
                    state_d = is_store_i ? LSU_IDLE : LSU_DRAIN;
                end
            end
            LSU_DRAIN: begin
                if (drain_done_i) begin
                    state_d = LSU_IDLE;
                end
            end
            default: state_d = LSU_IDLE;
        endcase
    end

    assign state_o       = state_q;
    assign count_clear_o = (state_q == LSU_IDLE) && start_i;

    a_idle_needs_start: assert property (@(posedge clk) disable iff (!reset_n)
        (state_q == LSU_IDLE && !start_i) |=> (state_q == LSU_IDLE))
        else $error("FSM left idle without a start pulse");

endmodule

/* src/vlsu_elem_counter.sv */
//////////////////////////////////////////////////
// Element counter
// Tracks the element index and the drain timer
//////////////////////////////////////////////////

`timescale 1ns/1ps

module vlsu_elem_counter (
    input  logic                  clk,
    input  logic                  reset_n,
    input  vlsu_pkg::lsu_state_e  state_i,
    input  logic                  count_clear_i,
    input  vlsu_pkg::elem_width_e width_i,
    input  logic [3:0]            vl_i,
    output vlsu_pkg::elem_idx_t   elem_idx_o,
    output logic                  last_elem_o,
    output logic                  drain_done_o
);
    import vlsu_pkg::*;

    logic [3:0] elems_per_reg;
    logic [3:0] active_count;
    logic [1:0] drain_cnt;
    elem_idx_t  idx_q;

    assign elems_per_reg = 4'(VLENB >> width_i);
    assign active_count  = (vl_i < elems_per_reg) ? vl_i : elems_per_reg;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            idx_q <= '0;
        end else if (count_clear_i) begin
            idx_q <= '0;
        end else if (state_i == LSU_ACCESS) begin
            idx_q <= idx_q + 3'd1;
        end
    end

    // Zero count still ends after a single access
    assign last_elem_o = ({1'b0, idx_q} + 4'd1) >= active_count;
    assign elem_idx_o  = idx_q;

    ////////////////////////////////////////////////
    // Drain timer
    ////////////////////////////////////////////////

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            drain_cnt <= '0;
        end else if (state_i != LSU_DRAIN) begin
            drain_cnt <= '0;
        end else begin
            drain_cnt <= drain_cnt + 2'd1;
        end
    end

    assign drain_done_o = (state_i == LSU_DRAIN) && (drain_cnt == 2'(READ_LATENCY - 1));

    a_idx_in_range: assert property (@(posedge clk) disable iff (!reset_n)
        (state_i == LSU_ACCESS) |-> ({1'b0, idx_q} < elems_per_reg))
        else $error("Element index beyond register");

endmodule

/* src/vlsu_addr_gen.sv */
//////////////////////////////////////////////////
// Address generator
// Base plus running stride or per-element offset
//////////////////////////////////////////////////

`timescale 1ns/1ps

module vlsu_addr_gen (
    input  logic                  clk,
    input  logic                  reset_n,
    input  vlsu_pkg::lsu_state_e  state_i,
    input  logic                  count_clear_i,
    input  logic                  indexed_i,
    input  vlsu_pkg::elem_width_e width_i,
    input  vlsu_pkg::addr_t       base_address_i,
    input  vlsu_pkg::addr_t       stride_i,
    input  vlsu_pkg::vreg_t       indexed_offsets_i,
    input  vlsu_pkg::elem_idx_t   elem_idx_i,
    output vlsu_pkg::addr_t       address_o
);
    import vlsu_pkg::*;

    addr_t stride_off;
    addr_t index_off;
    logic  misaligned;

    // Offset for element i is i times the stride
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            stride_off <= '0;
        end else if (count_clear_i) begin
            stride_off <= '0;
        end else if (state_i == LSU_ACCESS) begin
            stride_off <= stride_off + stride_i;
        end
    end

    // Indexed offsets are unsigned and zero-extended
    always_comb begin
        unique case (width_i)
            EW8:     index_off = {24'h0, indexed_offsets_i[{elem_idx_i, 3'b000} +: 8]};
            EW16:    index_off = {16'h0, indexed_offsets_i[{elem_idx_i[1:0], 4'b0000} +: 16]};
            default: index_off = indexed_offsets_i[{elem_idx_i[0], 5'b00000} +: 32];
        endcase
    end

    assign address_o = base_address_i + (indexed_i ? index_off : stride_off);

    assign misaligned = (width_i == EW16 && address_o[0])
                     || (width_i == EW32 && address_o[1:0] != 2'b00);

    a_addr_aligned: assert property (@(posedge clk) disable iff (!reset_n)
        (state_i == LSU_ACCESS) |-> !misaligned)
        else $error("Element address not aligned to its width");

endmodule

/* src/vlsu_store_lanes.sv */
//////////////////////////////////////////////////
// Store lane steering
// Byte enables and replicated data per element
//////////////////////////////////////////////////

`timescale 1ns/1ps

module vlsu_store_lanes (
    input  vlsu_pkg::lsu_state_e  state_i,
    input  logic                  is_store_i,
    input  vlsu_pkg::elem_width_e width_i,
    input  logic                  vm_i,
    input  vlsu_pkg::elem_mask_t  mask_i,
    input  vlsu_pkg::vreg_t       write_data_i,
    input  vlsu_pkg::elem_idx_t   elem_idx_i,
    input  vlsu_pkg::addr_t       address_i,
    output vlsu_pkg::byte_en_t    mem_write_enable_o,
    output vlsu_pkg::bus_data_t   mem_write_data_o
);
    import vlsu_pkg::*;

    byte_en_t lanes;
    logic     elem_active;

    // Copy the element into every lane it could land on
    always_comb begin
        unique case (width_i)
            EW8: begin
                mem_write_data_o = {4{write_data_i[{elem_idx_i, 3'b000} +: 8]}};
            end
            EW16: begin
                mem_write_data_o = {2{write_data_i[{elem_idx_i[1:0], 4'b0000} +: 16]}};
            end
            default: begin
                mem_write_data_o = write_data_i[{elem_idx_i[0], 5'b00000} +: 32];
            end
        endcase
    end

    // Lanes covered by the element at its byte offset
    always_comb begin
        unique case (width_i)
            EW8:     lanes = 4'b0001 << address_i[1:0];
            EW16:    lanes = 4'b0011 << {address_i[1], 1'b0};
            default: lanes = 4'b1111;
        endcase
    end

    assign elem_active = (state_i == LSU_ACCESS) && is_store_i
                      && (vm_i || mask_i[elem_idx_i]);

    assign mem_write_enable_o = elem_active ? lanes : '0;

endmodule

/* src/vlsu_load_gather.sv */
//////////////////////////////////////////////////
// Load gather
// Tracks loads in flight and fills the result
//////////////////////////////////////////////////

`timescale 1ns/1ps

module vlsu_load_gather (
    input  logic                  clk,
    input  logic                  reset_n,
    input  vlsu_pkg::lsu_state_e  state_i,
    input  logic                  count_clear_i,
    input  logic                  is_store_i,
    input  vlsu_pkg::elem_width_e width_i,
    input  vlsu_pkg::elem_idx_t   elem_idx_i,
    input  vlsu_pkg::addr_t       address_i,
    input  vlsu_pkg::bus_data_t   mem_read_data_i,
    output vlsu_pkg::vreg_t       read_data_o
);
    import vlsu_pkg::*;

    logic      s1_valid;
    logic      s2_valid;
    elem_idx_t s1_idx;
    elem_idx_t s2_idx;
    logic[1:0] s1_off;
    logic[1:0] s2_off;
    bus_data_t lane_data;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
        end else begin
            s1_valid <= (state_i == LSU_ACCESS) && !is_store_i;
            s2_valid <= s1_valid;
        end
    end

    // Slot and byte offset ride along with the valid bit
    always_ff @(posedge clk) begin
        s1_idx <= elem_idx_i;
        s1_off <= address_i[1:0];
        s2_idx <= s1_idx;
        s2_off <= s1_off;
    end

    // Bring the addressed byte lane down to bit 0
    assign lane_data = mem_read_data_i >> {s2_off, 3'b000};

    ////////////////////////////////////////////////
    // Result register
    ////////////////////////////////////////////////

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            read_data_o <= '0;
        end else if (count_clear_i) begin
            read_data_o <= '0;
        end else if (s2_valid) begin
            unique case (width_i)
                EW8: begin
                    read_data_o[{s2_idx, 3'b000} +: 8] <= lane_data[7:0];
                end
                EW16: begin
                    read_data_o[{s2_idx[1:0], 4'b0000} +: 16] <= lane_data[15:0];
                end
                default: begin
                    read_data_o[{s2_idx[0], 5'b00000} +: 32] <= lane_data;
                end
            endcase
        end
    end

endmodule

/* src/vlsu_top.sv */
//////////////////////////////////////////////////
// Vector load/store unit
// One element per cycle on a 32-bit memory bus
//////////////////////////////////////////////////

`timescale 1ns/1ps

module vlsu_top (
    input  logic                  clk,
    input  logic                  reset_n,
    input  logic                  start_i,
    input  logic                  is_store_i,
    input  logic                  indexed_i,
    input  vlsu_pkg::elem_width_e width_i,
    input  vlsu_pkg::addr_t       base_address_i,
    input  vlsu_pkg::addr_t       stride_i,
    input  vlsu_pkg::vreg_t       indexed_offsets_i,
    input  vlsu_pkg::vreg_t       write_data_i,
    input  logic [3:0]            vl_i,
    input  logic                  vm_i,
    input  vlsu_pkg::elem_mask_t  mask_i,
    input  vlsu_pkg::bus_data_t   mem_read_data_i,
    output logic                  hold_o,
    output vlsu_pkg::addr_t       mem_address_o,
    output logic                  mem_read_enable_o,
    output vlsu_pkg::byte_en_t    mem_write_enable_o,
    output vlsu_pkg::bus_data_t   mem_write_data_o,
    output vlsu_pkg::vreg_t       read_data_o
);
    import vlsu_pkg::*;

    lsu_state_e state;
    lsu_state_e xfer_state;
    logic       count_clear;
    logic       last_elem;
    logic       drain_done;
    logic       no_elems;
    elem_idx_t  elem_idx;
    addr_t      address;

    // Zero length still takes one access slot but moves no data
    assign no_elems   = (vl_i == 4'd0);
    assign xfer_state = no_elems ? LSU_IDLE : state;

    vlsu_fsm vlsu_fsm_inst (
        .clk           (clk),
        .reset_n       (reset_n),
        .start_i       (start_i),
        .is_store_i    (is_store_i),
        .last_elem_i   (last_elem),
        .drain_done_i  (drain_done),
        .state_o       (state),
        .count_clear_o (count_clear)
    );

    vlsu_elem_counter vlsu_elem_counter_inst (
        .clk           (clk),
        .reset_n       (reset_n),
        .state_i       (state),
        .count_clear_i (count_clear),
        .width_i       (width_i),
        .vl_i          (vl_i),
        .elem_idx_o    (elem_idx),
        .last_elem_o   (last_elem),
        .drain_done_o  (drain_done)
    );

    vlsu_addr_gen vlsu_addr_gen_inst (
        .clk               (clk),
        .reset_n           (reset_n),
        .state_i           (state),
        .count_clear_i     (count_clear),
        .indexed_i         (indexed_i),
        .width_i           (width_i),
        .base_address_i    (base_address_i),
        .stride_i          (stride_i),
        .indexed_offsets_i (indexed_offsets_i),
        .elem_idx_i        (elem_idx),
        .address_o         (address)
    );

    vlsu_store_lanes vlsu_store_lanes_inst (
        .state_i            (xfer_state),
        .is_store_i         (is_store_i),
        .width_i            (width_i),
        .vm_i               (vm_i),
        .mask_i             (mask_i),
        .write_data_i       (write_data_i),
        .elem_idx_i         (elem_idx),
        .address_i          (address),
        .mem_write_enable_o (mem_write_enable_o),
        .mem_write_data_o   (mem_write_data_o)
    );

    vlsu_load_gather vlsu_load_gather_inst (
        .clk             (clk),
        .reset_n         (reset_n),
        .state_i         (xfer_state),
        .count_clear_i   (count_clear),
        .is_store_i      (is_store_i),
        .width_i         (width_i),
        .elem_idx_i      (elem_idx),
        .address_i       (address),
        .mem_read_data_i (mem_read_data_i),
        .read_data_o     (read_data_o)
    );

    ////////////////////////////////////////////////
    // Bus side outputs
    ////////////////////////////////////////////////

    assign hold_o            = (state == LSU_ACCESS) || (state == LSU_DRAIN);
    assign mem_address_o     = address;
    assign mem_read_enable_o = (xfer_state == LSU_ACCESS) && !is_store_i;

endmodule

/* testbench/tb_vlsu.sv */
//////////////////////////////////////////////////
// Testbench for the vector load/store unit
// Memory model, random loads and stores, checks
//////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_vlsu;
    import vlsu_pkg::*;

    logic        clk;
    logic        reset_n;
    logic        start_i;
    logic        is_store_i;
    logic        indexed_i;
    elem_width_e width_i;
    addr_t       base_address_i;
    addr_t       stride_i;
    vreg_t       indexed_offsets_i;
    vreg_t       write_data_i;
    logic [3:0]  vl_i;
    logic        vm_i;
    elem_mask_t  mask_i;
    bus_data_t   mem_read_data_i;
    logic        hold_o;
    addr_t       mem_address_o;
    logic        mem_read_enable_o;
    byte_en_t    mem_write_enable_o;
    bus_data_t   mem_write_data_o;
    vreg_t       read_data_o;

    logic [7:0]  mem [0:255];
    logic [7:0]  exp_mem [0:255];
    logic [7:0]  rd_addr_q1 = '0;
    logic [7:0]  rd_addr_q2 = '0;
    logic [31:0] lfsr_state = 32'hdd7ea0db;
    int          errors = 0;
    int          tests = 0;
    int          failed_tests = 0;

    vlsu_top vlsu_top_inst (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    //////////////////////////////////////////////////
    // Memory model, two-cycle read latency
    //////////////////////////////////////////////////

    always @(posedge clk) begin
        rd_addr_q1 <= {mem_address_o[7:2], 2'b00};
        rd_addr_q2 <= rd_addr_q1;
        for (int b = 0; b < 4; b++) begin
            if (mem_write_enable_o[b]) begin
                mem[{mem_address_o[7:2], 2'(b)}] <= mem_write_data_o[8*b +: 8];
            end
        end
    end

    assign mem_read_data_i = {mem[{rd_addr_q2[7:2], 2'd3}], mem[{rd_addr_q2[7:2], 2'd2}],
                              mem[{rd_addr_q2[7:2], 2'd1}], mem[{rd_addr_q2[7:2], 2'd0}]};

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [63:0] random_bits(input int count);
        logic [63:0] r;
        r = '0;
        for (int k = 0; k < count; k++) begin
            lfsr_state = lfsr_next(lfsr_state);
            r = {r[62:0], lfsr_state[0]};
        end
        return r;
    endfunction

    // Applies a store to exp_mem, or returns the gathered load value
    function automatic vreg_t reference_access(input bit store, input bit idx, input int w,
        input addr_t base, input addr_t stride, input vreg_t offs, input vreg_t wdata,
        input int vl, input bit vm, input elem_mask_t mask);
        vreg_t      result;
        int         eb;
        int         n;
        addr_t      off;
        logic [7:0] a;
        result = '0;
        eb = 1 << w;
        n = (vl < 8 / eb) ? vl : 8 / eb;
        for (int i = 0; i < n; i++) begin
            off = idx ? '0 : addr_t'(i) * stride;
            for (int b = 0; b < eb && idx; b++) begin
                off = off | (addr_t'(offs[(i*eb+b)*8 +: 8]) << (8*b));
            end
            for (int b = 0; b < eb; b++) begin
                a = 8'(base + off + b);
                if (!store) begin
                    result[(i*eb+b)*8 +: 8] = exp_mem[a];
                end else if (vm || mask[i]) begin
                    exp_mem[a] = wdata[(i*eb+b)*8 +: 8];
                end
            end
        end
        return result;
    endfunction

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (actual !== expected) begin
            $display("Fail %s: expected %h, actual %h", name, expected, actual);
            errors++;
        end
    endtask

    // One access with random operands, optional start pulse during hold
    task automatic run_op(input string name, input bit store, input bit idx,
                          input int w, input bit vm, input bit poke);
        vreg_t expected;
        int    n;
        int    exp_hold;
        int    exp_rd;
        int    cycles;
        int    rd_cycles;
        int    errs_before;
        errs_before = errors;
        @(negedge clk);
        is_store_i        = store;
        indexed_i         = idx;
        width_i           = elem_width_e'(w);
        base_address_i    = addr_t'(random_bits(6)) & ~addr_t'((1 << w) - 1);
        stride_i          = addr_t'(random_bits(4)) << w;
        indexed_offsets_i = '0;
        for (int i = 0; i < (8 >> w); i++) begin
            indexed_offsets_i[(i << w)*8 +: 8] = 8'(random_bits(8)) & ~8'((1 << w) - 1);
        end
        write_data_i = random_bits(64);
        vl_i         = 4'(random_bits(4));
        vm_i         = vm;
        mask_i       = 8'(random_bits(8));
        start_i      = 1'b1;
        for (int a = 0; a < 256; a++) begin
            exp_mem[a] = mem[a];
        end
        expected = reference_access(store, idx, w, base_address_i, stride_i,
                                    indexed_offsets_i, write_data_i, vl_i, vm, mask_i);
        n = (vl_i < (8 >> w)) ? vl_i : (8 >> w);
        exp_hold = ((n == 0) ? 1 : n) + (store ? 0 : READ_LATENCY);
        // One read enable per active load element, none for stores
        exp_rd = store ? 0 : n;
        @(negedge clk);
        start_i = 1'b0;
        cycles = 0;
        rd_cycles = 0;
        while (hold_o && cycles < 32) begin
            cycles++;
            if (mem_read_enable_o) begin
                rd_cycles++;
            end
            start_i = poke && (cycles == 2);
            @(negedge clk);
        end
        start_i = 1'b0;
        if (hold_o) begin
            $display("Timeout: hold_o never fell during %s", name);
            $display(">>> FAIL");
            $finish;
        end else begin
            check_value($sformatf("%s hold cycles", name), exp_hold, cycles);
            check_value($sformatf("%s read enable cycles", name), exp_rd, rd_cycles);
            if (store) begin
                for (int a = 0; a < 256; a++) begin
                    check_value($sformatf("%s byte %0d", name, a), exp_mem[a], mem[a]);
                end
            end else begin
                check_value(name, expected, read_data_o);
            end
            tests++;
            if (errors != errs_before) failed_tests++;
            $display("%s: %s", name, (errors == errs_before) ? "ok" : "wrong");
        end
    endtask

    //////////////////////////////////////////////////
    // Test sequence
    //////////////////////////////////////////////////

    initial begin
        reset_n           = 1'b0;
        start_i           = 1'b0;
        is_store_i        = 1'b0;
        indexed_i         = 1'b0;
        width_i           = EW8;
        base_address_i    = '0;
        stride_i          = '0;
        indexed_offsets_i = '0;
        write_data_i      = '0;
        vl_i              = '0;
        vm_i              = 1'b1;
        mask_i            = '0;
        for (int a = 0; a < 256; a++) begin
            mem[a] = 8'(random_bits(8));
        end
        repeat (3) @(negedge clk);
        reset_n = 1'b1;
        @(negedge clk);
        check_value("reset hold_o", 0, hold_o);
        check_value("reset write enables", 0, mem_write_enable_o);
        check_value("reset read enable", 0, mem_read_enable_o);
        check_value("reset read_data_o", 0, read_data_o);
        tests++;
        if (errors != 0) failed_tests++;
        $display("reset_values: %s", (errors == 0) ? "ok" : "wrong");

        for (int i = 0; i < 6; i++) begin
            run_op($sformatf("strided_load_%0d", i), 1'b0, 1'b0, i % 3, i % 2, i % 2);
        end
        for (int i = 0; i < 6; i++) begin
            run_op($sformatf("indexed_load_%0d", i), 1'b0, 1'b1, i % 3, i % 2, 1'b0);
        end
        // Unmasked stores, strided and indexed in turn
        for (int i = 0; i < 6; i++) begin
            run_op($sformatf("store_%0d", i), 1'b1, i % 2, i % 3, 1'b1, i % 2);
        end
        for (int i = 0; i < 6; i++) begin
            run_op($sformatf("masked_store_%0d", i), 1'b1, i % 2, i % 3, 1'b0, 1'b0);
        end

        $display("%0d tests, %0d failed, %0d mismatches", tests, failed_tests, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

/* build.f */
src/vlsu_pkg.sv
src/vlsu_fsm.sv
src/vlsu_elem_counter.sv
src/vlsu_addr_gen.sv
src/vlsu_store_lanes.sv
src/vlsu_load_gather.sv
src/vlsu_top.sv
testbench/tb_vlsu.sv
